// File: rtl/bitmanip_pkg.sv
`default_nettype none

package bitmanip_pkg;

    // ----------------------------------------------------------------------
    // cluster sizing
    // ----------------------------------------------------------------------

    // the lane count is kept to a power of two so that indices wrap naturally.
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int TAG_W      = 4;

    // ----------------------------------------------------------------------
    // counting constants
    // ----------------------------------------------------------------------

    // masks for the octal (three-bit group) SWAR population count.
    localparam logic [31:0] SWAR_MASK_1 = 32'hdb6d_b6db;
    localparam logic [31:0] SWAR_MASK_2 = 32'h4924_9249;
    localparam logic [31:0] SWAR_MASK_3 = 32'hc71c_71c7;

    // the six-bit group sums fold into the final count modulo 63.
    localparam logic [31:0] FOLD_MODULUS = 32'd63;

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------

    // codes 6 and 7 are reserved and return zero.
    typedef enum logic [2:0] {
        OP_HAMMING_DIST = 3'd0,
        OP_POPCOUNT     = 3'd1,
        OP_PACK         = 3'd2,
        OP_REVERSE      = 3'd3,
        OP_SHIFT1_ADD   = 3'd4,
        OP_CTZ          = 3'd5
    } op_e;

    typedef struct packed {
        op_e               op;
        logic [31:0]       rs1;
        logic [31:0]       rs2;
        logic [TAG_W-1:0]  tag;
    } bm_req_t;

    typedef struct packed {
        logic [31:0]       result;
        logic [TAG_W-1:0]  tag;
    } bm_rsp_t;

    typedef enum logic {
        LANE_IDLE = 1'b0,
        LANE_FOLD = 1'b1
    } lane_state_e;

endpackage

`default_nettype wire

// File: rtl/op_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module op_dispatcher
    import bitmanip_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  req_valid_i,
    input  wire bm_req_t               req_i,
    input  wire logic [NUM_LANES-1:0]  lane_free_i,
    output logic                       stall_o,
    output logic [NUM_LANES-1:0]       issue_o,
    output bm_req_t                    issue_req_o
);

    logic [LANE_IDX_W-1:0] rr_ptr_q;
    logic [NUM_LANES-1:0]  busy_q;
    logic                  accept;

    // ----------------------------------------------------------------------
    // issue decision
    // ----------------------------------------------------------------------

    // issue is strictly rotational. waiting on the lane in turn, instead of
    // skipping to any free lane, keeps issue order equal to queue order.
    assign stall_o = req_valid_i && busy_q[rr_ptr_q];
    assign accept  = req_valid_i && !busy_q[rr_ptr_q];

    always_comb begin
        issue_o = '0;
        if (accept) begin
            issue_o[rr_ptr_q] = 1'b1;
        end
    end

    // every lane sees the same request and only the strobed one takes it.
    assign issue_req_o = req_i;

    // ----------------------------------------------------------------------
    // pointer and busy bookkeeping
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= '0;
            busy_q   <= '0;
        end else begin
            if (accept) begin
                rr_ptr_q <= rr_ptr_q + 1'b1;
            end
            // a lane cannot be freed and issued in the same cycle.
            busy_q <= (busy_q | issue_o) & ~lane_free_i;
        end
    end

    // the collector only frees lanes that are still marked busy.
    free_only_busy_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (lane_free_i & ~busy_q) == '0
    );

endmodule

`default_nettype wire

// File: rtl/bitmanip_lane.sv
`timescale 1ns/10ps
`default_nettype none

module bitmanip_lane
    import bitmanip_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     issue_i,
    input  wire bm_req_t  req_i,
    output logic          done_o,
    output bm_rsp_t       rsp_o
);

    lane_state_e state_q;
    logic        done_q;
    bm_rsp_t     rsp_q;
    logic [31:0] partial_q;

    logic        is_fold_op;
    logic [31:0] fold_src;
    logic [31:0] fold_partial;
    logic [31:0] quick_result;

    // ----------------------------------------------------------------------
    // helper functions
    // ----------------------------------------------------------------------

    // first step of the octal count, leaving one sum per six-bit group.
    function automatic logic [31:0] swar_partial(input logic [31:0] x);
        logic [31:0] v;
        v = x - ((x >> 1) & SWAR_MASK_1) - ((x >> 2) & SWAR_MASK_2);
        return (v + (v >> 3)) & SWAR_MASK_3;
    endfunction

    // binary search for the lowest set bit, halving the window each level.
    function automatic logic [31:0] ctz32(input logic [31:0] val);
        logic [31:0] x;
        logic [5:0]  n;
        int          w;
        x = val;
        n = '0;
        if (val == '0) begin
            return 32'd32;
        end
        for (int lvl = 4; lvl >= 0; lvl--) begin
            w = 1 << lvl;
            if ((x & ((32'd1 << w) - 32'd1)) == '0) begin
                n = n + 6'(w);
                x = x >> w;
            end
        end
        return {26'd0, n};
    endfunction

    // ----------------------------------------------------------------------
    // operation decode
    // ----------------------------------------------------------------------

    assign is_fold_op   = (req_i.op == OP_HAMMING_DIST) || (req_i.op == OP_POPCOUNT);
    assign fold_src     = (req_i.op == OP_HAMMING_DIST) ? (req_i.rs1 ^ req_i.rs2) : req_i.rs1;
    assign fold_partial = swar_partial(fold_src);

    always_comb begin
        case (req_i.op)
            OP_PACK:       quick_result = {req_i.rs2[15:0], req_i.rs1[15:0]};
            OP_REVERSE:    quick_result = {<<{req_i.rs1}};
            OP_SHIFT1_ADD: quick_result = (req_i.rs1 << 1) + req_i.rs2;
            OP_CTZ:        quick_result = ctz32(req_i.rs1);
            // counting ops overwrite this in the fold cycle.
            default:       quick_result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // control FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= LANE_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                LANE_IDLE: begin
                    if (issue_i) begin
                        if (is_fold_op) begin
                            state_q <= LANE_FOLD;
                        end else begin
                            done_q <= 1'b1;
                        end
                    end
                end
                LANE_FOLD: begin
                    state_q <= LANE_IDLE;
                    done_q  <= 1'b1;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // result datapath
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            rsp_q.tag    <= req_i.tag;
            rsp_q.result <= quick_result;
            partial_q    <= fold_partial;
        end else if (state_q == LANE_FOLD) begin
            rsp_q.result <= partial_q % FOLD_MODULUS;
        end
    end

    assign done_o = done_q;
    assign rsp_o  = rsp_q;

    // the dispatcher must hold off this lane until its fold has finished.
    no_issue_in_fold_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        issue_i |-> (state_q == LANE_IDLE)
    );

endmodule

`default_nettype wire

// File: rtl/result_collector.sv
`timescale 1ns/10ps
`default_nettype none

module result_collector
    import bitmanip_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic [NUM_LANES-1:0]  issue_i,
    input  wire logic [NUM_LANES-1:0]  done_i,
    input  wire bm_rsp_t               lane_rsp_i [NUM_LANES],
    output logic [NUM_LANES-1:0]       lane_free_o,
    output logic                       rsp_valid_o,
    output bm_rsp_t                    rsp_o
);

    bm_rsp_t               slot_q [NUM_LANES];
    logic [NUM_LANES-1:0]  slot_full_q;
    logic [NUM_LANES-1:0]  pending_q;
    logic [LANE_IDX_W-1:0] order_q [NUM_LANES];
    logic [LANE_IDX_W-1:0] wr_ptr_q;
    logic [LANE_IDX_W-1:0] rd_ptr_q;
    logic [LANE_IDX_W:0]   count_q;

    logic [LANE_IDX_W-1:0] issue_idx;
    logic [LANE_IDX_W-1:0] head_idx;
    logic                  push;
    logic                  head_ready;
    logic [NUM_LANES-1:0]  retire_vec;
    bm_rsp_t               head_rsp;

    always_comb begin
        issue_idx = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (issue_i[l]) begin
                issue_idx = LANE_IDX_W'(l);
            end
        end
    end

    assign push     = |issue_i;
    assign head_idx = order_q[rd_ptr_q];

    // a result arriving this cycle at the head bypasses its slot.
    assign head_ready = (count_q != '0) && (slot_full_q[head_idx] || done_i[head_idx]);
    assign head_rsp   = slot_full_q[head_idx] ? slot_q[head_idx] : lane_rsp_i[head_idx];

    always_comb begin
        retire_vec = '0;
        if (head_ready) begin
            retire_vec[head_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_full_q <= '0;
            pending_q   <= '0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            rsp_valid_o <= 1'b0;
            lane_free_o <= '0;
        end else begin
            slot_full_q <= (slot_full_q | done_i) & ~retire_vec;
            pending_q   <= (pending_q | issue_i) & ~retire_vec;
            wr_ptr_q    <= wr_ptr_q + LANE_IDX_W'(push);
            rd_ptr_q    <= rd_ptr_q + LANE_IDX_W'(head_ready);
            count_q     <= count_q + (LANE_IDX_W+1)'(push) - (LANE_IDX_W+1)'(head_ready);
            rsp_valid_o <= head_ready;
            lane_free_o <= retire_vec;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            order_q[wr_ptr_q] <= issue_idx;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (done_i[l]) begin
                slot_q[l] <= lane_rsp_i[l];
            end
        end
        if (head_ready) begin
            rsp_o <= head_rsp;
        end
    end

    // a lane only reports a result it was issued and has not yet handed over.
    done_expected_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (done_i & (slot_full_q | ~pending_q)) == '0
    );

endmodule

`default_nettype wire

// File: rtl/bitmanip_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module bitmanip_cluster
    import bitmanip_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     req_valid_i,
    input  wire bm_req_t  req_i,
    output logic          stall_o,
    output logic          rsp_valid_o,
    output bm_rsp_t       rsp_o
);

    logic [NUM_LANES-1:0] issue;
    logic [NUM_LANES-1:0] lane_free;
    logic [NUM_LANES-1:0] lane_done;
    bm_req_t              issue_req;
    bm_rsp_t              lane_rsp [NUM_LANES];

    op_dispatcher u_dispatcher (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .lane_free_i (lane_free),
        .stall_o     (stall_o),
        .issue_o     (issue),
        .issue_req_o (issue_req)
    );

    // ----------------------------------------------------------------------
    // execution lanes
    // ----------------------------------------------------------------------

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        bitmanip_lane u_lane (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .issue_i (issue[g]),
            .req_i   (issue_req),
            .done_o  (lane_done[g]),
            .rsp_o   (lane_rsp[g])
        );
    end

    result_collector u_collector (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue),
        .done_i      (lane_done),
        .lane_rsp_i  (lane_rsp),
        .lane_free_o (lane_free),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// bit-serial models of each opcode, written independently of the lane datapath.

function automatic logic [31:0] count_ones(input logic [31:0] val);
    logic [31:0] n;
    n = '0;
    for (int i = 0; i < 32; i++) begin
        n = n + 32'(val[i]);
    end
    return n;
endfunction

function automatic logic [31:0] reverse_bits(input logic [31:0] val);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
        r[i] = val[31-i];
    end
    return r;
endfunction

// scanning downwards leaves the index of the lowest set bit, or 32 for zero.
function automatic logic [31:0] count_trailing_zeros(input logic [31:0] val);
    logic [31:0] n;
    n = 32'd32;
    for (int i = 31; i >= 0; i--) begin
        if (val[i]) begin
            n = 32'(i);
        end
    end
    return n;
endfunction

function automatic logic [31:0] expected_result(
    input logic [2:0]  op,
    input logic [31:0] rs1,
    input logic [31:0] rs2
);
    logic [31:0] r;
    case (op)
        OP_HAMMING_DIST: r = count_ones(rs1 ^ rs2);
        OP_POPCOUNT:     r = count_ones(rs1);
        OP_PACK:         r = {rs2[15:0], rs1[15:0]};
        OP_REVERSE:      r = reverse_bits(rs1);
        OP_SHIFT1_ADD:   r = {rs1[30:0], 1'b0} + rs2;
        OP_CTZ:          r = count_trailing_zeros(rs1);
        default:         r = '0;
    endcase
    return r;
endfunction

`endif

// File: testbench/tb_bitmanip_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bitmanip_cluster
    import bitmanip_pkg::*;
();

    `include "tb_ref_model.svh"

    localparam int DIRECTED_REQS   = 24;
    localparam int MIXED_REQS      = 8;
    localparam int STALL_REQS      = 12;
    localparam int RESERVED_REQS   = 2;
    localparam int RANDOM_REQS     = 300;
    localparam int TOTAL_REQS      = DIRECTED_REQS + MIXED_REQS + STALL_REQS
                                     + RESERVED_REQS + RANDOM_REQS;
    localparam int TIMEOUT_CYCLES  = 20 * TOTAL_REQS + 100;
    localparam int MAX_RSP_LATENCY = 8;
    localparam int DRAIN_CYCLES    = 4 * MAX_RSP_LATENCY;

    logic       clk_i;
    logic       rst_n_i;
    logic       req_valid_i;
    bm_req_t    req_i;
    logic       stall_o;
    logic       rsp_valid_o;
    bm_rsp_t    rsp_o;

    bm_rsp_t          exp_q [$];
    int               accept_q [$];
    bm_rsp_t          exp_rsp     = '0;
    logic             exp_avail   = 1'b0;
    int               rsp_latency = 0;
    int               cycle_count = 0;
    logic             quiet_window = 1'b0;
    logic [TAG_W-1:0] next_tag = '0;
    logic [31:0]      dir_rs1 [4];
    logic [31:0]      dir_rs2 [4];

    bitmanip_cluster dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .stall_o     (stall_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    task automatic report_failure(input string what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge.
    task automatic send_request(
        input logic [2:0]  op,
        input logic [31:0] rs1,
        input logic [31:0] rs2
    );
        bm_req_t req;
        bm_rsp_t exp;
        req.op  = op_e'(op);
        req.rs1 = rs1;
        req.rs2 = rs2;
        req.tag = next_tag;
        next_tag = next_tag + 1'b1;
        req_i       = req;
        req_valid_i = 1'b1;
        @(negedge clk_i);
        while (stall_o) begin
            @(negedge clk_i);
        end
        exp.result = expected_result(op, rs1, rs2);
        exp.tag    = req.tag;
        exp_q.push_back(exp);
        accept_q.push_back(cycle_count);
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
    endtask

    // waits for the outstanding responses, for at most DRAIN_CYCLES cycles.
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_request(3'($urandom_range(0, 5)), $urandom, $urandom);
        end
    endtask

    // ----------------------------------------------------------------------
    // response tracking and checks
    // ----------------------------------------------------------------------

    // the head is taken mid-cycle so that it is stable at the checking edge.
    always @(negedge clk_i) begin
        if (rst_n_i && rsp_valid_o) begin
            if (exp_q.size() != 0) begin
                exp_rsp     = exp_q.pop_front();
                rsp_latency = cycle_count - accept_q.pop_front();
                exp_avail   = 1'b1;
            end else begin
                exp_avail = 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout: the run did not complete within the cycle limit");
        end
    end

    rsp_expected_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> exp_avail
    ) else report_failure("a response arrived with no request outstanding");

    rsp_result_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && exp_avail) |-> (rsp_o.result == exp_rsp.result)
    ) else begin
        $display("[ERROR] rsp_o.result: got 0x%h, expected 0x%h",
                 $sampled(rsp_o.result), $sampled(exp_rsp.result));
        report_failure("response result mismatch");
    end

    rsp_tag_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && exp_avail) |-> (rsp_o.tag == exp_rsp.tag)
    ) else begin
        $display("[ERROR] rsp_o.tag: got 0x%h, expected 0x%h",
                 $sampled(rsp_o.tag), $sampled(exp_rsp.tag));
        report_failure("response tag mismatch");
    end

    rsp_latency_a : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && exp_avail) |-> (rsp_latency <= MAX_RSP_LATENCY)
    ) else report_failure("an accepted request waited too long for its response");

    quiet_after_reset_a : assert property (
        @(posedge clk_i)
        quiet_window |-> (!rsp_valid_o && !stall_o)
    ) else report_failure("rsp_valid_o or stall_o was high around reset");

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    initial begin
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        void'($urandom(32'h6ac9));

        dir_rs1[0] = 32'h0000_0000;
        dir_rs2[0] = 32'h0000_0000;
        dir_rs1[1] = 32'hffff_ffff;
        dir_rs2[1] = 32'hffff_ffff;
        dir_rs1[2] = 32'h0000_0010;
        dir_rs2[2] = 32'h0001_0000;
        dir_rs1[3] = 32'h8000_0000;
        dir_rs2[3] = 32'h0000_0001;

        @(posedge clk_i);
        #1;
        quiet_window = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        quiet_window = 1'b0;

        // each opcode alone on directed operands.
        for (int op = 0; op < 6; op++) begin
            for (int v = 0; v < 4; v++) begin
                send_request(3'(op), dir_rs1[v], dir_rs2[v]);
                wait_drain();
            end
        end

        // a two-cycle count followed at once by one-cycle ops on other lanes.
        send_request(OP_POPCOUNT, $urandom, $urandom);
        send_request(OP_PACK, $urandom, $urandom);
        send_request(OP_REVERSE, $urandom, $urandom);
        send_request(OP_CTZ, $urandom, $urandom);
        wait_drain();
        send_request(OP_HAMMING_DIST, $urandom, $urandom);
        send_request(OP_SHIFT1_ADD, $urandom, $urandom);
        send_request(OP_POPCOUNT, $urandom, $urandom);
        send_request(OP_PACK, $urandom, $urandom);
        wait_drain();

        // more requests than lanes, one per cycle.
        for (int i = 0; i < STALL_REQS; i++) begin
            send_request((i % 2 == 0) ? OP_POPCOUNT : OP_HAMMING_DIST, $urandom, $urandom);
        end
        wait_drain();

        send_request(3'd6, $urandom, $urandom);
        send_request(3'd7, $urandom, $urandom);
        wait_drain();

        send_random(RANDOM_REQS);
        wait_drain();

        repeat (5) @(posedge clk_i);
        if (exp_q.size() != 0) begin
            report_failure("responses are missing at the end of the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+testbench
rtl/bitmanip_pkg.sv
rtl/op_dispatcher.sv
rtl/bitmanip_lane.sv
rtl/result_collector.sv
rtl/bitmanip_cluster.sv
testbench/tb_bitmanip_cluster.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_bitmanip_cluster
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the binary exits with a failing status on any $fatal.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
